// File: files.f
design/sparse_pkg.sv
design/sparse_chunk_mem.sv
design/sparse_dot_beat.sv
design/filter_accum.sv
design/conv_ctrl.sv
design/sparse_conv_top.sv
test/tb_sparse_conv.sv

// File: test/tb_sparse_conv.sv
`timescale 1ns/1ps

module tb_sparse_conv;

	import sparse_pkg::*;

	localparam int NUM_ROWS = 7;
	localparam int RUN_TIMEOUT = 40;

	// Result arrival counted in cycles from the start pulse
	localparam int FIRST_RESULT = 6;
	localparam int RESULT_GAP = 4;
	localparam int LAST_RESULT = FIRST_RESULT + (FILTER_NUM - 1) * RESULT_GAP;

	logic                 gated_clk_w;
	logic                 rst_i;
	logic                 wr_valid_i;
	logic                 wr_target_i;
	filt_idx_t            wr_chunk_i;
	beat_cnt_t            wr_beat_i;
	map_t                 wr_map_i;
	elem_t [BUS_SIZE-1:0] wr_data_i;
	logic                 start_i;
	ifm_idx_t             start_ifm_i;
	logic                 busy_o;
	logic                 result_valid_o;
	acc_t                 result_o;
	filt_idx_t            result_filter_o;
	logic                 done_o;

	// Stimulus table, one row per data set
	logic        row_ifm     [NUM_ROWS];
	logic [31:0] row_f_mask  [NUM_ROWS];
	logic [31:0] row_x_mask  [NUM_ROWS];
	logic        row_busy_wr [NUM_ROWS];

	// Reference copy of both chunk memories
	logic [31:0] f_map_m [FILTER_NUM];
	logic [7:0]  f_val_m [FILTER_NUM][CHUNK_SIZE];
	logic [31:0] x_map_m [IFM_NUM];
	logic [7:0]  x_val_m [IFM_NUM][CHUNK_SIZE];

	logic [31:0] rng;
	int          checks;
	int          value_errors;
	int          other_errors;
	logic        aborted;

	sparse_conv_top i_dut (
		.gated_clk_w     (gated_clk_w),
		.rst_i           (rst_i),
		.wr_valid_i      (wr_valid_i),
		.wr_target_i     (wr_target_i),
		.wr_chunk_i      (wr_chunk_i),
		.wr_beat_i       (wr_beat_i),
		.wr_map_i        (wr_map_i),
		.wr_data_i       (wr_data_i),
		.start_i         (start_i),
		.start_ifm_i     (start_ifm_i),
		.busy_o          (busy_o),
		.result_valid_o  (result_valid_o),
		.result_o        (result_o),
		.result_filter_o (result_filter_o),
		.done_o          (done_o)
	);

	initial begin
		gated_clk_w = 1'b0;
		forever begin
			#5 gated_clk_w = ~gated_clk_w;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rotate_left(input logic [31:0] v, input int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// Masked signed dot product of one filter and one IFM chunk
	function automatic logic [23:0] expected_dot(input int f, input int x);
		int sum;
		int a;
		int b;
		sum = 0;
		for (int p = 0; p < CHUNK_SIZE; p++) begin
			if (f_map_m[f][p] && x_map_m[x][p]) begin
				a = $signed(f_val_m[f][p]);
				b = $signed(x_val_m[x][p]);
				sum = sum + a * b;
			end
		end
		return sum[23:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic load_table();
		row_ifm[0] = 1'b0;
		row_f_mask[0] = 32'hFFFF_FFFF;
		row_x_mask[0] = 32'hFFFF_FFFF;
		row_busy_wr[0] = 1'b0;
		row_ifm[1] = 1'b1;
		row_f_mask[1] = 32'h0F0F_0F0F;
		row_x_mask[1] = 32'h3C3C_3C3C;
		row_busy_wr[1] = 1'b0;
		row_ifm[2] = 1'b0;
		row_f_mask[2] = 32'h0000_0000;
		row_x_mask[2] = 32'hFFFF_FFFF;
		row_busy_wr[2] = 1'b0;
		row_ifm[3] = 1'b1;
		row_f_mask[3] = 32'hFFFF_FFFF;
		row_x_mask[3] = 32'h0000_0000;
		row_busy_wr[3] = 1'b1;
		row_ifm[4] = 1'b0;
		row_f_mask[4] = 32'h8040_2010;
		row_x_mask[4] = 32'hFFFF_0000;
		row_busy_wr[4] = 1'b1;
		// Alternating lanes in both maps
		row_ifm[5] = 1'b1;
		row_f_mask[5] = 32'hAAAA_AAAA;
		row_x_mask[5] = 32'h5555_5555;
		row_busy_wr[5] = 1'b0;
		row_ifm[6] = 1'b0;
		row_f_mask[6] = 32'h1357_9BDF;
		row_x_mask[6] = 32'hFEDC_BA98;
		row_busy_wr[6] = 1'b1;
	endtask

	// New map and values for one chunk of the model
	task automatic make_chunk(input logic is_ifm, input int c, input logic [31:0] mask);
		logic [31:0] map;
		logic [7:0]  v;
		rng = xorshift32(rng);
		map = rotate_left(mask, int'(rng[4:0]));
		for (int p = 0; p < CHUNK_SIZE; p++) begin
			rng = xorshift32(rng);
			v = rng[7:0];
			// Nonzero garbage where the map is 0
			if (!map[p] && v == 8'h00) begin
				v = 8'hA5;
			end
			if (is_ifm) begin
				x_val_m[c][p] = v;
			end else begin
				f_val_m[c][p] = v;
			end
		end
		if (is_ifm) begin
			x_map_m[c] = map;
		end else begin
			f_map_m[c] = map;
		end
	endtask

	// Starts and ends on a falling edge
	task automatic write_chunk(input logic is_ifm, input int c);
		logic [31:0] map;
		if (is_ifm) begin
			map = x_map_m[c];
		end else begin
			map = f_map_m[c];
		end
		for (int b = 0; b < BEAT_NUM; b++) begin
			wr_valid_i  = 1'b1;
			wr_target_i = is_ifm;
			wr_chunk_i  = filt_idx_t'(c);
			wr_beat_i   = beat_cnt_t'(b);
			wr_map_i    = map[b*BUS_SIZE +: BUS_SIZE];
			for (int i = 0; i < BUS_SIZE; i++) begin
				if (is_ifm) begin
					wr_data_i[i] = x_val_m[c][b*BUS_SIZE+i];
				end else begin
					wr_data_i[i] = f_val_m[c][b*BUS_SIZE+i];
				end
			end
			@(negedge gated_clk_w);
		end
		wr_valid_i = 1'b0;
	endtask

	////////////////////////////////////////
	// Run one IFM chunk against all filters
	////////////////////////////////////////

	task automatic run_and_check(input int x, input logic busy_write);
		logic [23:0] exp_res [FILTER_NUM];
		logic        exp_valid;
		logic        done_seen;
		int          cycle;
		int          seen;
		for (int f = 0; f < FILTER_NUM; f++) begin
			exp_res[f] = expected_dot(f, x);
		end
		check_value("busy_o", busy_o, 0);
		start_i     = 1'b1;
		start_ifm_i = ifm_idx_t'(x);
		cycle     = 0;
		seen      = 0;
		done_seen = 1'b0;
		while (!done_seen && cycle < RUN_TIMEOUT) begin
			@(negedge gated_clk_w);
			cycle++;
			start_i = 1'b0;
			exp_valid = (cycle >= FIRST_RESULT) && (cycle <= LAST_RESULT)
				&& ((cycle - FIRST_RESULT) % RESULT_GAP == 0);
			check_value("result_valid_o", result_valid_o, exp_valid);
			check_value("done_o", done_o, cycle == LAST_RESULT);
			check_value("busy_o", busy_o, cycle < LAST_RESULT);
			if (result_valid_o) begin
				if (seen < FILTER_NUM) begin
					check_value("result_filter_o", result_filter_o, seen);
					check_value("result_o", {8'h00, result_o}, {8'h00, exp_res[seen]});
				end
				seen++;
			end
			// Host write while busy leaves the model as it is
			if (busy_write && cycle == 8) begin
				rng = xorshift32(rng);
				wr_valid_i  = 1'b1;
				wr_target_i = rng[0];
				wr_chunk_i  = rng[0] ? filt_idx_t'(1 - x) : filt_idx_t'(rng[2:1]);
				wr_beat_i   = beat_cnt_t'(rng[4:3]);
				wr_map_i    = '1;
				wr_data_i   = {BUS_SIZE{8'h7F}};
			end else begin
				wr_valid_i = 1'b0;
			end
			done_seen = done_o;
		end
		if (!done_seen) begin
			$display("Timeout: done_o did not pulse within %0d cycles of start", RUN_TIMEOUT);
			other_errors++;
			aborted = 1'b1;
		end else if (seen != FILTER_NUM) begin
			$display("Run on IFM %0d returned %0d results instead of %0d", x, seen, FILTER_NUM);
			other_errors++;
		end
		// Controller returns to idle on the next edge
		@(negedge gated_clk_w);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		rst_i        = 1'b1;
		wr_valid_i   = 1'b0;
		wr_target_i  = 1'b0;
		wr_chunk_i   = '0;
		wr_beat_i    = '0;
		wr_map_i     = '0;
		wr_data_i    = '0;
		start_i      = 1'b0;
		start_ifm_i  = '0;
		rng          = 32'd48963;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		aborted      = 1'b0;
		load_table();
		for (int c = 0; c < FILTER_NUM; c++) begin
			f_map_m[c] = '0;
			for (int p = 0; p < CHUNK_SIZE; p++) begin
				f_val_m[c][p] = '0;
			end
		end
		for (int c = 0; c < IFM_NUM; c++) begin
			x_map_m[c] = '0;
			for (int p = 0; p < CHUNK_SIZE; p++) begin
				x_val_m[c][p] = '0;
			end
		end

		repeat (3) @(negedge gated_clk_w);
		rst_i = 1'b0;
		@(negedge gated_clk_w);
		check_value("busy_o", busy_o, 0);
		check_value("result_valid_o", result_valid_o, 0);
		check_value("done_o", done_o, 0);

		// Empty memories give four zero results
		run_and_check(0, 1'b0);

		for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
			for (int f = 0; f < FILTER_NUM; f++) begin
				make_chunk(1'b0, f, row_f_mask[r]);
				write_chunk(1'b0, f);
			end
			for (int x = 0; x < IFM_NUM; x++) begin
				make_chunk(1'b1, x, row_x_mask[r]);
				write_chunk(1'b1, x);
			end
			run_and_check(int'(row_ifm[r]), row_busy_wr[r]);
			// Same filters against the other IFM chunk
			if (!aborted) begin
				run_and_check(int'(!row_ifm[r]), 1'b0);
			end
		end

		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: design/sparse_conv_top.sv
`timescale 1ns/1ps

module sparse_conv_top (
	input  logic                                           gated_clk_w,
	input  logic                                           rst_i,

	// Host write port
	input  logic                                           wr_valid_i,
	input  logic                                           wr_target_i,
	input  sparse_pkg::filt_idx_t                          wr_chunk_i,
	input  sparse_pkg::beat_cnt_t                          wr_beat_i,
	input  sparse_pkg::map_t                               wr_map_i,
	input  sparse_pkg::elem_t [sparse_pkg::BUS_SIZE-1:0]   wr_data_i,

	// Run port
	input  logic                                           start_i,
	input  sparse_pkg::ifm_idx_t                           start_ifm_i,

	output logic                                           busy_o,
	output logic                                           result_valid_o,
	output sparse_pkg::acc_t                               result_o,
	output sparse_pkg::filt_idx_t                          result_filter_o,
	output logic                                           done_o
);

	import sparse_pkg::*;

	logic                 filt_wr_en;
	logic                 ifm_wr_en;
	filt_idx_t            rd_filter;
	ifm_idx_t             rd_ifm;
	beat_cnt_t            rd_beat;
	logic                 beat_valid;
	logic                 beat_first;
	logic                 beat_last;

	map_t                 f_map;
	elem_t [BUS_SIZE-1:0] f_data;
	map_t                 x_map;
	elem_t [BUS_SIZE-1:0] x_data;

	// Stage between the multiplier and the accumulator
	psum_t                psum;
	logic                 psum_valid;
	logic                 psum_first;
	logic                 psum_last;
	filt_idx_t            psum_filter;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	conv_ctrl i_ctrl (
		.gated_clk_w    (gated_clk_w),
		.rst_i          (rst_i),
		.wr_valid_i     (wr_valid_i),
		.wr_target_i    (wr_target_i),
		.start_i        (start_i),
		.start_ifm_i    (start_ifm_i),
		.result_valid_i (result_valid_o),
		.filt_wr_en_o   (filt_wr_en),
		.ifm_wr_en_o    (ifm_wr_en),
		.rd_filter_o    (rd_filter),
		.rd_ifm_o       (rd_ifm),
		.rd_beat_o      (rd_beat),
		.beat_valid_o   (beat_valid),
		.beat_first_o   (beat_first),
		.beat_last_o    (beat_last),
		.busy_o         (busy_o),
		.done_o         (done_o)
	);

	////////////////////////////////////////
	// Chunk memories
	////////////////////////////////////////

	sparse_chunk_mem #(.CHUNK_NUM(FILTER_NUM)) i_filter_mem (
		.gated_clk_w (gated_clk_w),
		.rst_i       (rst_i),
		.wr_en_i     (filt_wr_en),
		.wr_chunk_i  (wr_chunk_i),
		.wr_beat_i   (wr_beat_i),
		.wr_map_i    (wr_map_i),
		.wr_data_i   (wr_data_i),
		.rd_chunk_i  (rd_filter),
		.rd_beat_i   (rd_beat),
		.rd_map_o    (f_map),
		.rd_data_o   (f_data)
	);

	// Only the low chunk bits address the smaller IFM store
	sparse_chunk_mem #(.CHUNK_NUM(IFM_NUM)) i_ifm_mem (
		.gated_clk_w (gated_clk_w),
		.rst_i       (rst_i),
		.wr_en_i     (ifm_wr_en),
		.wr_chunk_i  (wr_chunk_i[$clog2(IFM_NUM)-1:0]),
		.wr_beat_i   (wr_beat_i),
		.wr_map_i    (wr_map_i),
		.wr_data_i   (wr_data_i),
		.rd_chunk_i  (rd_ifm),
		.rd_beat_i   (rd_beat),
		.rd_map_o    (x_map),
		.rd_data_o   (x_data)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	sparse_dot_beat i_dot (
		.gated_clk_w (gated_clk_w),
		.rst_i       (rst_i),
		.valid_i     (beat_valid),
		.first_i     (beat_first),
		.last_i      (beat_last),
		.filter_i    (rd_filter),
		.f_map_i     (f_map),
		.f_data_i    (f_data),
		.x_map_i     (x_map),
		.x_data_i    (x_data),
		.psum_o      (psum),
		.valid_o     (psum_valid),
		.first_o     (psum_first),
		.last_o      (psum_last),
		.filter_o    (psum_filter)
	);

	filter_accum i_accum (
		.gated_clk_w     (gated_clk_w),
		.rst_i           (rst_i),
		.valid_i         (psum_valid),
		.first_i         (psum_first),
		.last_i          (psum_last),
		.filter_i        (psum_filter),
		.psum_i          (psum),
		.result_valid_o  (result_valid_o),
		.result_o        (result_o),
		.result_filter_o (result_filter_o)
	);

endmodule

// File: design/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl (
	input  logic                  gated_clk_w,
	input  logic                  rst_i,

	// Host write strobe and target
	input  logic                  wr_valid_i,
	input  logic                  wr_target_i,

	// Run request
	input  logic                  start_i,
	input  sparse_pkg::ifm_idx_t  start_ifm_i,

	// Returning results
	input  logic                  result_valid_i,

	// Memory write enables
	output logic                  filt_wr_en_o,
	output logic                  ifm_wr_en_o,

	// Read indices
	output sparse_pkg::filt_idx_t rd_filter_o,
	output sparse_pkg::ifm_idx_t  rd_ifm_o,
	output sparse_pkg::beat_cnt_t rd_beat_o,

	// Beat flags to the datapath
	output logic                  beat_valid_o,
	output logic                  beat_first_o,
	output logic                  beat_last_o,

	output logic                  busy_o,
	output logic                  done_o
);

	import sparse_pkg::*;

	ctrl_state_t state_r;

	// Beats still being issued
	logic        issue_r;
	beat_cnt_t   beat_r;
	filt_idx_t   filt_r;
	ifm_idx_t    ifm_r;

	// Results seen so far in this run
	filt_idx_t   res_cnt_r;

	logic        idle_c;
	logic        last_beat_c;
	logic        last_filt_c;
	logic        done_c;

	assign idle_c      = (state_r == ST_IDLE);
	assign last_beat_c = (beat_r == beat_cnt_t'(BEAT_NUM - 1));
	assign last_filt_c = (filt_r == filt_idx_t'(FILTER_NUM - 1));

	// Fourth result closes the run
	assign done_c = (state_r == ST_RUN) && result_valid_i
		&& (res_cnt_r == filt_idx_t'(FILTER_NUM - 1));

	////////////////////////////////////////
	// Run FSM
	////////////////////////////////////////

	always_ff @(posedge gated_clk_w) begin
		if (rst_i) begin
			state_r   <= ST_IDLE;
			issue_r   <= 1'b0;
			beat_r    <= '0;
			filt_r    <= '0;
			ifm_r     <= '0;
			res_cnt_r <= '0;
		end else begin
			case (state_r)
				ST_IDLE: begin
					if (start_i) begin
						state_r   <= ST_RUN;
						issue_r   <= 1'b1;
						beat_r    <= '0;
						filt_r    <= '0;
						ifm_r     <= start_ifm_i;
						res_cnt_r <= '0;
					end
				end
				ST_RUN: begin
					// Beat counter nested in the filter counter
					if (issue_r) begin
						beat_r <= beat_r + 1'b1;
						if (last_beat_c) begin
							filt_r <= filt_r + 1'b1;
							if (last_filt_c) begin
								issue_r <= 1'b0;
							end
						end
					end
					if (result_valid_i) begin
						res_cnt_r <= res_cnt_r + 1'b1;
					end
					if (done_c) begin
						state_r <= ST_IDLE;
					end
				end
				default: begin
					state_r <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	// Host writes land only between runs
	assign filt_wr_en_o = wr_valid_i && idle_c && !wr_target_i;
	assign ifm_wr_en_o  = wr_valid_i && idle_c && wr_target_i;

	assign rd_filter_o = filt_r;
	assign rd_ifm_o    = ifm_r;
	assign rd_beat_o   = beat_r;

	assign beat_valid_o = issue_r;
	assign beat_first_o = (beat_r == '0);
	assign beat_last_o  = last_beat_c;

	assign busy_o = (state_r == ST_RUN) && !done_c;
	assign done_o = done_c;

endmodule

// File: design/filter_accum.sv
`timescale 1ns/1ps

module filter_accum (
	input  logic                  gated_clk_w,
	input  logic                  rst_i,

	// Partial sum stream
	input  logic                  valid_i,
	input  logic                  first_i,
	input  logic                  last_i,
	input  sparse_pkg::filt_idx_t filter_i,
	input  sparse_pkg::psum_t     psum_i,

	// One result per filter
	output logic                  result_valid_o,
	output sparse_pkg::acc_t      result_o,
	output sparse_pkg::filt_idx_t result_filter_o
);

	import sparse_pkg::*;

	acc_t psum_ext_c;
	acc_t acc_next_c;
	acc_t acc_r;

	assign psum_ext_c = acc_t'(psum_i);

	// First beat of a filter restarts the sum
	assign acc_next_c = first_i ? psum_ext_c : acc_r + psum_ext_c;

	always_ff @(posedge gated_clk_w) begin
		if (valid_i) begin
			acc_r <= acc_next_c;
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge gated_clk_w) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= valid_i && last_i;
		end
	end

	// Held until the next filter completes
	always_ff @(posedge gated_clk_w) begin
		if (valid_i && last_i) begin
			result_o        <= acc_next_c;
			result_filter_o <= filter_i;
		end
	end

endmodule

// File: design/sparse_dot_beat.sv
`timescale 1ns/1ps

module sparse_dot_beat (
	input  logic                                           gated_clk_w,
	input  logic                                           rst_i,

	// Beat flags from the controller
	input  logic                                           valid_i,
	input  logic                                           first_i,
	input  logic                                           last_i,
	input  sparse_pkg::filt_idx_t                          filter_i,

	// Filter beat
	input  sparse_pkg::map_t                               f_map_i,
	input  sparse_pkg::elem_t [sparse_pkg::BUS_SIZE-1:0]   f_data_i,

	// IFM beat
	input  sparse_pkg::map_t                               x_map_i,
	input  sparse_pkg::elem_t [sparse_pkg::BUS_SIZE-1:0]   x_data_i,

	output sparse_pkg::psum_t                              psum_o,
	output logic                                           valid_o,
	output logic                                           first_o,
	output logic                                           last_o,
	output sparse_pkg::filt_idx_t                          filter_o
);

	import sparse_pkg::*;

	map_t  both_map_c;
	psum_t prod_c [BUS_SIZE];
	psum_t sum_c;

	// A lane counts only where both maps hold a 1
	assign both_map_c = f_map_i & x_map_i;

	// Products are formed at full psum width so nothing wraps
	always_comb begin
		for (int i = 0; i < BUS_SIZE; i++) begin
			if (both_map_c[i]) begin
				prod_c[i] = $signed(f_data_i[i]) * $signed(x_data_i[i]);
			end else begin
				prod_c[i] = '0;
			end
		end
	end

	// Adder over the eight lanes
	always_comb begin
		sum_c = '0;
		for (int i = 0; i < BUS_SIZE; i++) begin
			sum_c = sum_c + prod_c[i];
		end
	end

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////

	always_ff @(posedge gated_clk_w) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge gated_clk_w) begin
		psum_o   <= sum_c;
		first_o  <= first_i;
		last_o   <= last_i;
		filter_o <= filter_i;
	end

endmodule

// File: design/sparse_chunk_mem.sv
`timescale 1ns/1ps

module sparse_chunk_mem #(
	parameter int CHUNK_NUM = sparse_pkg::FILTER_NUM
) (
	input  logic                                           gated_clk_w,
	input  logic                                           rst_i,

	// Write port, one beat per strobe
	input  logic                                           wr_en_i,
	input  logic [$clog2(CHUNK_NUM)-1:0]                   wr_chunk_i,
	input  sparse_pkg::beat_cnt_t                          wr_beat_i,
	input  sparse_pkg::map_t                               wr_map_i,
	input  sparse_pkg::elem_t [sparse_pkg::BUS_SIZE-1:0]   wr_data_i,

	// Read port
	input  logic [$clog2(CHUNK_NUM)-1:0]                   rd_chunk_i,
	input  sparse_pkg::beat_cnt_t                          rd_beat_i,
	output sparse_pkg::map_t                               rd_map_o,
	output sparse_pkg::elem_t [sparse_pkg::BUS_SIZE-1:0]   rd_data_o
);

	import sparse_pkg::*;

	// Storage, chunk by beat
	map_t                 map_r  [CHUNK_NUM][BEAT_NUM];
	elem_t [BUS_SIZE-1:0] data_r [CHUNK_NUM][BEAT_NUM];

	////////////////////////////////////////
	// Write
	////////////////////////////////////////

	// Whole array comes up as zeros so an unwritten chunk reads as empty
	always_ff @(posedge gated_clk_w) begin
		if (rst_i) begin
			for (int c = 0; c < CHUNK_NUM; c++) begin
				for (int b = 0; b < BEAT_NUM; b++) begin
					map_r[c][b]  <= '0;
					data_r[c][b] <= '0;
				end
			end
		end else if (wr_en_i) begin
			map_r[wr_chunk_i][wr_beat_i]  <= wr_map_i;
			data_r[wr_chunk_i][wr_beat_i] <= wr_data_i;
		end
	end

	////////////////////////////////////////
	// Read
	////////////////////////////////////////

	// Combinational beat select
	assign rd_map_o  = map_r[rd_chunk_i][rd_beat_i];
	assign rd_data_o = data_r[rd_chunk_i][rd_beat_i];

endmodule

// File: design/sparse_pkg.sv
package sparse_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Elements carried by one bus beat
	localparam int BUS_SIZE = 8;

	// Elements held in one chunk
	localparam int CHUNK_SIZE = 32;

	localparam int BEAT_NUM = CHUNK_SIZE / BUS_SIZE;

	// Chunks held in each memory
	localparam int FILTER_NUM = 4;
	localparam int IFM_NUM = 2;

	localparam int ELEM_W = 8;

	// Eight 16-bit products summed need three more bits
	localparam int PSUM_W = 2 * ELEM_W + $clog2(BUS_SIZE);

	localparam int ACC_W = 24;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [BUS_SIZE-1:0] map_t;
	typedef logic signed [ELEM_W-1:0] elem_t;

	typedef logic [$clog2(BEAT_NUM)-1:0] beat_cnt_t;
	typedef logic [$clog2(FILTER_NUM)-1:0] filt_idx_t;
	typedef logic [$clog2(IFM_NUM)-1:0] ifm_idx_t;

	typedef logic signed [PSUM_W-1:0] psum_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// Run controller
	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} ctrl_state_t;

endpackage
